// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module uart_io_tb -f sources.f -o uart_io_sim \
  || exit 1
out=$(./obj_dir/uart_io_sim 2>&1)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: sources.f
+incdir+verilog
verilog/fabric_pkg.sv
verilog/gateway_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/gateway.sv
verilog/uart_io.sv
verif/uart_io_tb.sv

// File: verif/uart_io_tb.sv
// uart debug gateway testbench
`timescale 1ns/10ps

`include "uart_io_params.svh"

module uart_io_tb;
  import fabric_pkg::*;
  import gateway_pkg::*;

  localparam int CLKS = `UART_CLKS_PER_BIT;
  localparam int MAX_VEC = 32;

  logic        clk = 1'b0;
  logic        rst;
  logic        uart_master_tx;
  logic        uart_master_rx;
  t_fabric_req fabric_req;
  t_fabric_rsp fabric_rsp;
  logic        fabric_stall;

  logic [127:0] v_name    [MAX_VEC];
  int           v_stop    [MAX_VEC];
  logic [7:0]   v_cmd     [MAX_VEC];
  int           v_nbyte   [MAX_VEC];
  logic [63:0]  v_payload [MAX_VEC];
  int           v_req     [MAX_VEC];
  logic [1:0]   v_op      [MAX_VEC];
  logic [31:0]  v_addr    [MAX_VEC];
  logic [31:0]  v_data    [MAX_VEC];
  int           v_nrep    [MAX_VEC];
  logic [39:0]  v_reply   [MAX_VEC];
  int           n_vec;
  longint       limit_ns;
  bit           loaded;
  bit           failed;
  t_fabric_req  req_q [$]; // requests seen by the fabric model
  t_uart_byte   rx_q [$];  // bytes decoded from the reply line
  logic [31:0]  lfsr_q = 32'hcde4;

  uart_io i_uart_io (
    .clk            (clk),
    .rst            (rst),
    .uart_master_tx (uart_master_tx),
    .uart_master_rx (uart_master_rx),
    .fabric_req     (fabric_req),
    .fabric_rsp     (fabric_rsp),
    .fabric_stall   (fabric_stall)
  );

  always #5 clk = ~clk;

  task automatic abort_run();
    failed = 1'b1;
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failure");
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[6:0], lfsr_q[0]};
    end
  endtask

  task automatic check_req(input logic [127:0] test, input t_fabric_req exp,
                           input t_fabric_req act);
    if (act !== exp) begin
      $display("error %0s fabric request expected %h actual %h", test, exp, act);
      abort_run();
    end
  endtask

  task automatic check_byte(input logic [127:0] test, input t_uart_byte exp,
                            input t_uart_byte act);
    if (act !== exp) begin
      $display("error %0s reply byte expected %h actual %h", test, exp, act);
      abort_run();
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    int    total;
    string line;
    fd = $fopen("verif/uart_io_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vectors file");
      abort_run();
    end
    n_vec = 0;
    total = 0;
    while (!$feof(fd) && n_vec < MAX_VEC) begin
      n = $fgets(line, fd);
      if (n > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %d %h %d %h %d %h %h %h %d %h", v_name[n_vec], v_stop[n_vec],
                    v_cmd[n_vec], v_nbyte[n_vec], v_payload[n_vec], v_req[n_vec],
                    v_op[n_vec], v_addr[n_vec], v_data[n_vec], v_nrep[n_vec],
                    v_reply[n_vec]);
        if (n != 11) begin
          $display("malformed line in the vectors file: %0s", line);
          abort_run();
        end
        total += 1 + v_nbyte[n_vec] + v_nrep[n_vec];
        n_vec++;
      end
    end
    $fclose(fd);
    limit_ns = 2 * longint'(total) * 10 * CLKS * 10 + 10000;
  endtask

  // host side serial driver, lsb first
  task automatic send_byte(input logic [7:0] data, input bit stop_ok);
    uart_master_tx = 1'b0;
    repeat (CLKS) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      uart_master_tx = data[i];
      repeat (CLKS) @(negedge clk);
    end
    if (stop_ok) begin
      uart_master_tx = 1'b1;
      repeat (CLKS) @(negedge clk);
    end else begin
      uart_master_tx = 1'b0; // low through the receiver's mid-bit sample
      repeat (CLKS * 3 / 4) @(negedge clk);
      uart_master_tx = 1'b1;
      repeat (CLKS / 4) @(negedge clk);
    end
  endtask

  task automatic wait_reply_byte(input logic [127:0] test, output t_uart_byte b);
    int n;
    n = 0;
    while (rx_q.size() == 0 && n < 64 * CLKS) begin
      @(negedge clk);
      n++;
    end
    if (rx_q.size() == 0) begin
      $display("no reply byte arrived from the DUT in test %0s", test);
      abort_run();
    end else begin
      b = rx_q.pop_front();
    end
  endtask

  task automatic run_vector(input int v);
    t_uart_byte  got;
    t_uart_byte  exp_b;
    t_fabric_req exp_r;
    int          nb;
    nb = v_nbyte[v];
    send_byte(v_cmd[v], v_stop[v] != 0);
    for (int i = 0; i < nb; i++)
      send_byte(v_payload[v][8*(nb-1-i) +: 8], 1'b1);
    for (int i = 0; i < v_nrep[v]; i++) begin
      wait_reply_byte(v_name[v], got);
      exp_b.valid = 1'b1;
      exp_b.data  = v_reply[v][8*(v_nrep[v]-1-i) +: 8];
      check_byte(v_name[v], exp_b, got);
    end
    repeat (24 * CLKS) @(negedge clk); // room for a late or duplicate byte
    if (rx_q.size() != 0) begin
      $display("test %0s got more reply bytes than expected", v_name[v]);
      abort_run();
    end
    if (req_q.size() != v_req[v]) begin
      $display("test %0s saw %0d fabric requests instead of %0d", v_name[v],
               req_q.size(), v_req[v]);
      abort_run();
    end
    if (v_req[v] != 0) begin
      exp_r.valid     = 1'b1;
      exp_r.opcode    = t_opcode'(v_op[v]);
      exp_r.address   = v_addr[v];
      exp_r.data      = v_data[v];
      exp_r.thread_id = '0;
      check_req(v_name[v], exp_r, req_q.pop_front());
    end
  endtask

  // fabric memory model with random latency and stall bursts
  initial begin
    logic [31:0] mem [16];
    logic [7:0]  r;
    int          rsp_wait;
    int          stall_left;
    t_fabric_rsp pending;
    fabric_stall = 1'b0;
    fabric_rsp   = '0;
    rsp_wait     = 0;
    stall_left   = 0;
    pending      = '0;
    for (int i = 0; i < 16; i++)
      mem[i] = {8{4'(i)}} ^ 32'h5a5a5a5a;
    forever begin
      @(negedge clk);
      fabric_rsp = '0;
      if (!rst) begin
        if (rsp_wait > 0) begin
          rsp_wait--;
          if (rsp_wait == 0) begin
            fabric_rsp = pending;
          end else begin
            draw_bits(2, r);
            if (r == 8'd0) begin // wrong opcode, must be ignored
              fabric_rsp        = pending;
              fabric_rsp.opcode = (pending.opcode == RD_RSP) ? WR_RSP : RD_RSP;
              fabric_rsp.data   = 32'hdead0bad;
            end
          end
        end
        if (stall_left == 0) begin
          draw_bits(1, r);
          fabric_stall = r[0];
          draw_bits(4, r);
          stall_left = int'(r) + 1;
        end else begin
          stall_left--;
        end
        #1; // request settles on the new stall level
        if (fabric_req.valid) begin
          if (fabric_stall) begin
            $display("fabric request was issued while fabric_stall was high");
            abort_run();
          end
          req_q.push_back(fabric_req);
          pending.valid     = 1'b1;
          pending.thread_id = fabric_req.thread_id;
          if (fabric_req.opcode == WR) begin
            mem[fabric_req.address[5:2]] = fabric_req.data;
            pending.opcode = WR_RSP;
            pending.data   = '0;
          end else begin
            pending.opcode = RD_RSP;
            pending.data   = mem[fabric_req.address[5:2]];
          end
          draw_bits(3, r);
          rsp_wait = int'(r) + 1; // 1 to 8 cycles
        end
      end
    end
  end

  // reply line monitor, samples at mid-bit
  initial begin
    t_uart_byte b;
    forever begin
      @(negedge clk);
      if (rst === 1'b0 && uart_master_rx === 1'b0) begin
        repeat (CLKS / 2) @(negedge clk);
        if (uart_master_rx !== 1'b0) begin
          $display("reply line start bit was too short");
          abort_run();
        end
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS) @(negedge clk);
          b.data[i] = uart_master_rx;
        end
        repeat (CLKS) @(negedge clk);
        if (uart_master_rx !== 1'b1) begin
          $display("reply byte arrived with a low stop bit");
          abort_run();
        end
        b.valid = 1'b1;
        rx_q.push_back(b);
      end
    end
  end

  initial begin
    wait (loaded);
    #(limit_ns);
    $display("timeout after %0d ns, the DUT stopped answering", limit_ns);
    abort_run();
  end

  initial begin
    rst            = 1'b1;
    uart_master_tx = 1'b1;
    failed         = 1'b0;
    loaded         = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    repeat (2) @(negedge clk);
    if (fabric_req.valid !== 1'b0 || uart_master_rx !== 1'b1) begin
      $display("DUT outputs were not idle after reset");
      abort_run();
    end
    for (int v = 0; v < n_vec; v++)
      run_vector(v);
    if (!failed) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// File: verif/uart_io_vectors.txt
# name stop cmd nbyte payload req op address data nrep reply
# stop 0 sends a low stop bit, op 0 read 2 write, payload and reply hex msb first
wr_a     1 57 8 00000010cafef00d 1 2 00000010 cafef00d 1 57
rd_a     1 52 4 00000010         1 0 00000010 00000000 5 52cafef00d
wr_b     1 57 8 0000003c12345678 1 2 0000003c 12345678 1 57
rd_b     1 52 4 0000003c         1 0 0000003c 00000000 5 5212345678
unk_x    1 58 0 0                0 0 00000000 00000000 1 3f
rd_init  1 52 4 00000024         1 0 00000024 00000000 5 52c3c3c3c3
brk_w    0 57 0 0                0 0 00000000 00000000 0 0
wr_c     1 57 8 ffff0004a5a5a5a5 1 2 ffff0004 a5a5a5a5 1 57
rd_c     1 52 4 ffff0004         1 0 ffff0004 00000000 5 52a5a5a5a5
unk_nul  1 00 0 0                0 0 00000000 00000000 1 3f
wr_e     1 57 8 0000002000000000 1 2 00000020 00000000 1 57
rd_e     1 52 4 00000020         1 0 00000020 00000000 5 5200000000
brk_r    0 52 0 0                0 0 00000000 00000000 0 0
wr_f     1 57 8 00000008deadbeef 1 2 00000008 deadbeef 1 57
rd_f     1 52 4 00000008         1 0 00000008 00000000 5 52deadbeef
unk_q    1 3f 0 0                0 0 00000000 00000000 1 3f
wr_a2    1 57 8 000000100badf00d 1 2 00000010 0badf00d 1 57
rd_a2    1 52 4 00000010         1 0 00000010 00000000 5 520badf00d
rd_b2    1 52 4 0000003c         1 0 0000003c 00000000 5 5212345678
rd_zero  1 52 4 00000000         1 0 00000000 00000000 5 525a5a5a5a

// File: verilog/fabric_pkg.sv
// fabric port types
package fabric_pkg;

`include "uart_io_params.svh"

  typedef enum logic [1:0] {
    RD     = 2'b00,
    RD_RSP = 2'b01,
    WR     = 2'b10,
    WR_RSP = 2'b11
  } t_opcode;

  // request toward the core fabric
  typedef struct packed {
    logic                      valid;
    t_opcode                   opcode;
    logic [`FABRIC_ADDR_W-1:0] address;
    logic [`FABRIC_DATA_W-1:0] data;
    logic [`FABRIC_TID_W-1:0]  thread_id;
  } t_fabric_req;

  // response from the fabric
  typedef struct packed {
    logic                      valid;
    t_opcode                   opcode;
    logic [`FABRIC_DATA_W-1:0] data;
    logic [`FABRIC_TID_W-1:0]  thread_id;
  } t_fabric_rsp;

endpackage

// File: verilog/gateway.sv
// command frame gateway
// serial frames to fabric requests and back
`timescale 1ns/10ps

`include "uart_io_params.svh"

module gateway (
  input  logic                    clk,
  input  logic                    rst,
  input  gateway_pkg::t_uart_byte rx_byte,
  input  logic                    tx_busy,
  output gateway_pkg::t_uart_byte tx_byte,
  output fabric_pkg::t_fabric_req fabric_req,
  input  fabric_pkg::t_fabric_rsp fabric_rsp,
  input  logic                    fabric_stall
);
  import fabric_pkg::*;
  import gateway_pkg::*;

  localparam int AW = `FABRIC_ADDR_W;
  localparam int DW = `FABRIC_DATA_W;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_ISSUE,
    ST_AWAIT,
    ST_REPLY
  } t_gw_state;

  t_gw_state     state;
  logic          is_write;
  logic [1:0]    byte_cnt;   // position within address or data
  logic [2:0]    reply_left; // bytes still to send after the current one
  logic [AW-1:0] addr_q;
  logic [DW-1:0] data_q;
  logic [DW+7:0] reply_q;    // echo byte on top, read data below
  t_opcode       rsp_op;
  t_cmd_code     echo;
  logic          req_fire;
  logic          rsp_match;
  logic          reply_fire;
  logic          req_sent;   // request already issued in this frame

  assign rsp_op     = is_write ? WR_RSP : RD_RSP;
  assign echo       = is_write ? CMD_WRITE : CMD_READ;
  assign req_fire   = (state == ST_ISSUE) && !fabric_stall;
  assign rsp_match  = (state == ST_AWAIT) && fabric_rsp.valid && (fabric_rsp.opcode == rsp_op);
  assign reply_fire = (state == ST_REPLY) && !tx_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ST_IDLE;
      is_write   <= 1'b0;
      byte_cnt   <= '0;
      reply_left <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (rx_byte.valid) begin
            byte_cnt <= '0;
            case (rx_byte.data)
              CMD_WRITE: begin
                is_write <= 1'b1;
                state    <= ST_ADDR;
              end
              CMD_READ: begin
                is_write <= 1'b0;
                state    <= ST_ADDR;
              end
              default: begin // unknown, answer '?' only
                reply_left <= '0;
                state      <= ST_REPLY;
              end
            endcase
          end
        end
        ST_ADDR: begin
          if (rx_byte.valid) begin
            byte_cnt <= byte_cnt + 1'b1; // wraps to zero for data
            if (byte_cnt == 2'd3)
              state <= is_write ? ST_DATA : ST_ISSUE;
          end
        end
        ST_DATA: begin
          if (rx_byte.valid) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3)
              state <= ST_ISSUE;
          end
        end
        ST_ISSUE: if (req_fire) state <= ST_AWAIT; // held here while stalled
        ST_AWAIT: begin
          if (rsp_match) begin
            reply_left <= is_write ? 3'd0 : 3'd4;
            state      <= ST_REPLY;
          end
        end
        ST_REPLY: begin
          if (reply_fire) begin
            if (reply_left == 3'd0)
              state <= ST_IDLE;
            else
              reply_left <= reply_left - 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // frame payload, msb first
  always_ff @(posedge clk) begin
    if (state == ST_ADDR && rx_byte.valid)
      addr_q <= {addr_q[AW-9:0], rx_byte.data};
    if (state == ST_DATA && rx_byte.valid)
      data_q <= {data_q[DW-9:0], rx_byte.data};
    if (state == ST_IDLE && rx_byte.valid)
      reply_q[DW+7 -: 8] <= CMD_ERR;
    else if (rsp_match)
      reply_q <= {echo, fabric_rsp.data};
    else if (reply_fire)
      reply_q <= {reply_q[DW-1:0], 8'h00};
  end

  always_ff @(posedge clk) begin
    if (rst)
      req_sent <= 1'b0;
    else if (state == ST_IDLE)
      req_sent <= 1'b0;
    else if (req_fire)
      req_sent <= 1'b1;
  end

  always_comb begin
    fabric_req.valid     = req_fire;
    fabric_req.opcode    = is_write ? WR : RD;
    fabric_req.address   = addr_q;
    fabric_req.data      = is_write ? data_q : '0;
    fabric_req.thread_id = '0;
  end

  assign tx_byte = '{valid: reply_fire, data: reply_q[DW+7 -: 8]};

  a_no_req_in_stall: assert property (@(posedge clk) disable iff (rst)
    fabric_stall |-> !fabric_req.valid);

  // one request pulse until the frame is finished
  a_one_req_per_frame: assert property (@(posedge clk) disable iff (rst)
    fabric_req.valid |-> !req_sent);

endmodule

// File: verilog/gateway_pkg.sv
// serial gateway types
package gateway_pkg;

  // one byte between uart and gateway
  typedef struct packed {
    logic       valid; // single cycle strobe
    logic [7:0] data;
  } t_uart_byte;

  // command and reply codes, ascii
  typedef enum logic [7:0] {
    CMD_WRITE = 8'h57, // 'W'
    CMD_READ  = 8'h52, // 'R'
    CMD_ERR   = 8'h3f  // '?'
  } t_cmd_code;

endpackage

// File: verilog/uart_io.sv
// uart debug gateway top
`timescale 1ns/10ps

module uart_io (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    uart_master_tx, // from host
  output logic                    uart_master_rx, // to host
  output fabric_pkg::t_fabric_req fabric_req,
  input  fabric_pkg::t_fabric_rsp fabric_rsp,
  input  logic                    fabric_stall
);
  import gateway_pkg::*;

  t_uart_byte rx_byte;
  t_uart_byte tx_byte;
  logic       tx_busy;

  uart_rx i_uart_rx (
    .clk       (clk),
    .rst       (rst),
    .serial_in (uart_master_tx),
    .rx_byte   (rx_byte)
  );

  gateway i_gateway (
    .clk          (clk),
    .rst          (rst),
    .rx_byte      (rx_byte),
    .tx_busy      (tx_busy),
    .tx_byte      (tx_byte),
    .fabric_req   (fabric_req),
    .fabric_rsp   (fabric_rsp),
    .fabric_stall (fabric_stall)
  );

  // reply path back to the host
  uart_tx i_uart_tx (
    .clk        (clk),
    .rst        (rst),
    .tx_byte    (tx_byte),
    .tx_busy    (tx_busy),
    .serial_out (uart_master_rx)
  );

endmodule

// File: verilog/uart_io_params.svh
// uart debug gateway
// bit timing and fabric widths
`ifndef UART_IO_PARAMS_SVH
`define UART_IO_PARAMS_SVH

// serial bit period in clock cycles
`define UART_CLKS_PER_BIT 16

// fabric port widths
`define FABRIC_ADDR_W 32
`define FABRIC_DATA_W 32
`define FABRIC_TID_W  2

`endif

// File: verilog/uart_rx.sv
// uart receiver
`timescale 1ns/10ps

`include "uart_io_params.svh"

module uart_rx (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    serial_in,
  output gateway_pkg::t_uart_byte rx_byte
);
  import gateway_pkg::*;

  localparam int CLKS = `UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CLKS);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS - 1);
  localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} t_rx_state;

  t_rx_state        state;
  logic [1:0]       sync_q;
  logic             line;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift_q;
  logic             valid_q;

  assign line = sync_q[1]; // synchronized serial line

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= RX_IDLE;
      sync_q  <= 2'b11;
      cnt     <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], serial_in};
      valid_q <= 1'b0;
      case (state)
        RX_IDLE: begin
          if (!line) begin // falling start edge
            state <= RX_START;
            cnt   <= '0;
          end
        end
        RX_START: begin
          if (cnt == HALF) begin
            cnt     <= '0;
            bit_idx <= '0;
            // glitch if the line went back high
            state   <= line ? RX_IDLE : RX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt == LAST) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7)
              state <= RX_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (cnt == LAST) begin
            valid_q <= line; // low stop bit drops the byte
            state   <= RX_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk) begin
    if (state == RX_DATA && cnt == LAST)
      shift_q <= {line, shift_q[7:1]};
  end

  assign rx_byte = '{valid: valid_q, data: shift_q};

  a_rx_strobe: assert property (@(posedge clk) disable iff (rst)
    rx_byte.valid |=> !rx_byte.valid);

endmodule

// File: verilog/uart_tx.sv
// uart transmitter
`timescale 1ns/10ps

`include "uart_io_params.svh"

module uart_tx (
  input  logic                    clk,
  input  logic                    rst,
  input  gateway_pkg::t_uart_byte tx_byte,
  output logic                    tx_busy,
  output logic                    serial_out
);
  import gateway_pkg::*;

  localparam int CLKS = `UART_CLKS_PER_BIT;
  localparam int CNT_W = $clog2(CLKS);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS - 1);

  logic             busy_q;
  logic [CNT_W-1:0] cnt;
  logic [3:0]       bit_idx;  // 0 start .. 9 stop
  logic [9:0]       shift_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
      shift_q <= '1; // line idles high
    end else if (!busy_q && tx_byte.valid) begin
      shift_q <= {1'b1, tx_byte.data, 1'b0}; // stop, data, start
      busy_q  <= 1'b1;
      cnt     <= '0;
      bit_idx <= '0;
    end else if (busy_q) begin
      if (cnt == LAST) begin
        cnt     <= '0;
        shift_q <= {1'b1, shift_q[9:1]};
        if (bit_idx == 4'd9)
          busy_q <= 1'b0; // stop bit done
        else
          bit_idx <= bit_idx + 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  assign tx_busy    = busy_q;
  assign serial_out = shift_q[0];

  // the gateway must wait for an idle transmitter
  a_tx_no_overrun: assert property (@(posedge clk) disable iff (rst)
    tx_byte.valid |-> !tx_busy);

endmodule
